/* tb.f */
+incdir+design
design/scope_pkg.sv
design/host_request_decoder.sv
design/acquisition_ctrl.sv
design/sample_buffer.sv
design/readout_sequencer.sv
design/scope_top.sv
verif/tb_clock_gen.sv
verif/tb_scope.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scope testbench with Verilator
# Pass only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module tb_scope -o tb_scope_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_scope_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Pass line not found in $LOG"
    exit 1
fi

/* verif/tb_scope.sv */
// Scope capture testbench
// Drives host writes and sample strobes, mirrors the buffer in a model
// and compares the output stream with the expected word list
`timescale 1ns/1ps
`default_nettype none
`include "scope_macros.svh"

module tb_scope import scope_pkg::*; ();

    typedef struct packed {
        logic      is_status;
        reg_data_t data;
    } exp_word_t;
    typedef exp_word_t exp_list_t[$];

    localparam reg_data_t BIT_START = reg_data_t'(1 << `SCOPE_START_IDX);
    localparam reg_data_t BIT_STOP  = reg_data_t'(1 << `SCOPE_STOP_IDX);
    localparam reg_data_t BIT_CH1   = reg_data_t'(1 << `SCOPE_RQST_CH1_IDX);
    localparam reg_data_t BIT_CH2   = reg_data_t'(1 << `SCOPE_RQST_CH2_IDX);
    localparam reg_data_t BIT_TRIG  = reg_data_t'(1 << `SCOPE_RQST_TRIG_IDX);
    localparam reg_data_t BIT_CLEAR = reg_data_t'(1 << `SCOPE_CLEAR_IDX);
    // Quiet cycles after a drained readout to catch stray words
    localparam int QUIET_CYCLES = 8;
    // Rough cycle budget: reset, then the six behaviors in order
    localparam int TEST_CYCLES = 16 + 60 + 90 + 120 + 20 + 60 + 25;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 200;

    logic         clk;
    logic         rst;
    reg_addr_t    reg_addr;
    reg_data_t    reg_data;
    logic         reg_wr;
    sample_t      ch1_sample;
    sample_t      ch2_sample;
    logic         sample_valid;
    logic         out_valid;
    logic         out_is_status;
    reg_data_t    out_data;

    // Model of the capture state
    sample_pair_t model_mem [0:15];
    buf_ptr_t     model_ptr;
    logic         model_wrapped;
    logic         model_trig;
    buf_ptr_t     model_trig_pos;
    sample_t      model_prev_ch1;
    sample_t      model_level;
    logic         model_running;
    logic [31:0]  rand_state;
    int           cycle_count = 0;
    exp_word_t    exp_q[$];

    tb_clock_gen i_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    scope_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .reg_addr      (reg_addr),
        .reg_data      (reg_data),
        .reg_wr        (reg_wr),
        .ch1_sample    (ch1_sample),
        .ch2_sample    (ch2_sample),
        .sample_valid  (sample_valid),
        .out_valid     (out_valid),
        .out_is_status (out_is_status),
        .out_data      (out_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Expected words for one request write, ch1 then ch2 then status
    function automatic exp_list_t expected_words(input reg_data_t bits);
        exp_list_t words;
        exp_word_t w;
        int        count;
        int        i;
        buf_ptr_t  first;
        buf_ptr_t  idx;
        count = model_wrapped ? 16 : int'(model_ptr);
        first = model_wrapped ? model_ptr : '0;
        if (bits[`SCOPE_RQST_CH1_IDX]) begin
            for (i = 0; i < count; i++) begin
                idx = first + buf_ptr_t'(i);
                w.is_status = 1'b0;
                w.data = {`SCOPE_TAG_CH1, model_mem[idx].ch1};
                words.push_back(w);
            end
        end
        if (bits[`SCOPE_RQST_CH2_IDX]) begin
            for (i = 0; i < count; i++) begin
                idx = first + buf_ptr_t'(i);
                w.is_status = 1'b0;
                w.data = {`SCOPE_TAG_CH2, model_mem[idx].ch2};
                words.push_back(w);
            end
        end
        if (bits[`SCOPE_RQST_TRIG_IDX]) begin
            w.is_status = 1'b1;
            w.data = {model_running, model_trig, model_wrapped, 9'd0, model_trig_pos};
            words.push_back(w);
        end
        return words;
    endfunction

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected,
                     $time);
            stop_with_failure();
        end
    endtask

    // Clear wins, then stop, then start
    task automatic apply_request(input reg_data_t bits);
        if (bits[`SCOPE_CLEAR_IDX]) begin
            model_ptr      = '0;
            model_wrapped  = 1'b0;
            model_trig     = 1'b0;
            model_trig_pos = '0;
            model_prev_ch1 = '0;
            model_running  = 1'b0;
        end else if (bits[`SCOPE_STOP_IDX] || bits[`SCOPE_RQST_CH1_IDX]
                     || bits[`SCOPE_RQST_CH2_IDX]) begin
            model_running = 1'b0;
        end else if (bits[`SCOPE_START_IDX]) begin
            model_running = 1'b1;
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        exp_list_t words;
        @(posedge clk);
        #10;
        reg_addr = addr;
        reg_data = data;
        reg_wr   = 1'b1;
        if (addr == `SCOPE_REQ_ADDR) begin
            apply_request(data);
            words = expected_words(data);
            foreach (words[i]) exp_q.push_back(words[i]);
        end else if (addr == `SCOPE_TRIG_ADDR) begin
            model_level = data[7:0];
        end
        @(posedge clk);
        #10;
        reg_wr = 1'b0;
    endtask

    // One strobed pair, stored by the model only while running
    task automatic strobe_sample();
        sample_pair_t pair;
        rand_state = lcg_next(rand_state);
        pair.ch1 = rand_state[23:16];
        rand_state = lcg_next(rand_state);
        pair.ch2 = rand_state[23:16];
        @(posedge clk);
        #10;
        ch1_sample   = pair.ch1;
        ch2_sample   = pair.ch2;
        sample_valid = 1'b1;
        if (model_running) begin
            if (!model_trig && pair.ch1 >= model_level && model_prev_ch1 < model_level) begin
                model_trig     = 1'b1;
                model_trig_pos = model_ptr;
            end
            model_mem[model_ptr] = pair;
            model_prev_ch1 = pair.ch1;
            if (model_ptr == 4'hf) begin
                model_wrapped = 1'b1;
            end
            model_ptr = model_ptr + 1'b1;
        end
        @(posedge clk);
        #10;
        sample_valid = 1'b0;
    endtask

    task automatic strobe_samples(input int n);
        repeat (n) strobe_sample();
    endtask

    task automatic wait_readout();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (QUIET_CYCLES) @(posedge clk);
    endtask

    // Outputs settle after the rising edge, so look at the falling one
    always @(negedge clk) begin : compare_outputs
        exp_word_t w;
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("Output word 0x%0h arrived with no readout expected", out_data);
                stop_with_failure();
            end else begin
                w = exp_q.pop_front();
                check_value("out_data", 32'(out_data), 32'(w.data));
                check_value("out_is_status", 32'(out_is_status), 32'(w.is_status));
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Simulation ran past %0d cycles without finishing", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    initial begin
        reg_addr       = '0;
        reg_data       = '0;
        reg_wr         = 1'b0;
        ch1_sample     = '0;
        ch2_sample     = '0;
        sample_valid   = 1'b0;
        rand_state     = 32'd69;
        model_ptr      = '0;
        model_wrapped  = 1'b0;
        model_trig     = 1'b0;
        model_trig_pos = '0;
        model_prev_ch1 = '0;
        model_level    = '0;
        model_running  = 1'b0;
        foreach (model_mem[i]) model_mem[i] = '0;
        wait (rst == 1'b0);

        // Never started, nothing stored, unmapped write ignored
        strobe_samples(5);
        write_reg(`SCOPE_REQ_ADDR, BIT_CH1);
        wait_readout();
        write_reg(`SCOPE_REQ_ADDR, BIT_TRIG);
        wait_readout();
        write_reg(4'd5, 16'h003f);
        write_reg(`SCOPE_REQ_ADDR, BIT_TRIG);
        wait_readout();

        // Ten samples, ch1 readout stops capture
        write_reg(`SCOPE_TRIG_ADDR, 16'h0080);
        write_reg(`SCOPE_REQ_ADDR, BIT_START);
        strobe_samples(10);
        write_reg(`SCOPE_REQ_ADDR, BIT_CH1);
        wait_readout();
        // Held, so these are dropped
        strobe_samples(4);
        write_reg(`SCOPE_REQ_ADDR, BIT_CH1);
        wait_readout();

        // Wrapped capture, last 16 oldest first
        write_reg(`SCOPE_REQ_ADDR, BIT_CLEAR);
        write_reg(`SCOPE_REQ_ADDR, BIT_START);
        strobe_samples(37);
        write_reg(`SCOPE_REQ_ADDR, BIT_STOP);
        write_reg(`SCOPE_REQ_ADDR, BIT_CH2);
        wait_readout();

        // Status after the wrapped run
        write_reg(`SCOPE_REQ_ADDR, BIT_TRIG);
        wait_readout();

        // Queued jobs in one write
        write_reg(`SCOPE_REQ_ADDR, BIT_CH1 | BIT_CH2 | BIT_TRIG);
        wait_readout();

        // Clear then status
        write_reg(`SCOPE_REQ_ADDR, BIT_CLEAR);
        write_reg(`SCOPE_REQ_ADDR, BIT_TRIG);
        wait_readout();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// Testbench clock and reset source
// 100 ns clock, reset held high for the first 16 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Released shortly after an edge, same as the stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* design/scope_top.sv */
// Two-channel sample capture top
// Host decoder, acquisition control, sample RAM and readout stream
`timescale 1ns/1ps
`default_nettype none

module scope_top import scope_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire reg_addr_t reg_addr,
    input  wire reg_data_t reg_data,
    input  wire logic      reg_wr,
    input  wire sample_t   ch1_sample,
    input  wire sample_t   ch2_sample,
    input  wire logic      sample_valid,
    output logic           out_valid,
    output logic           out_is_status,
    output reg_data_t      out_data
);

    request_t     req;
    sample_t      trig_level;
    logic         wr_en;
    buf_ptr_t     wr_addr;
    sample_pair_t wr_data;
    acq_status_t  status;
    buf_ptr_t     wr_ptr;
    buf_ptr_t     rd_addr;
    sample_pair_t rd_data;

    host_request_decoder i_decoder (
        .clk        (clk),
        .rst        (rst),
        .reg_addr   (reg_addr),
        .reg_data   (reg_data),
        .reg_wr     (reg_wr),
        .req        (req),
        .trig_level (trig_level)
    );

    acquisition_ctrl i_acq (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .trig_level   (trig_level),
        .ch1_sample   (ch1_sample),
        .ch2_sample   (ch2_sample),
        .sample_valid (sample_valid),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .status       (status),
        .wr_ptr       (wr_ptr)
    );

    sample_buffer i_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    readout_sequencer i_readout (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .status        (status),
        .wr_ptr        (wr_ptr),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .out_valid     (out_valid),
        .out_is_status (out_is_status),
        .out_data      (out_data)
    );

endmodule

`default_nettype wire

/* design/readout_sequencer.sv */
// Readout sequencer
// Queues channel and status requests, streams tagged words oldest first
`timescale 1ns/1ps
`default_nettype none
`include "scope_macros.svh"

module readout_sequencer import scope_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire request_t     req,
    input  wire acq_status_t  status,
    input  wire buf_ptr_t     wr_ptr,
    output buf_ptr_t          rd_addr,
    input  wire sample_pair_t rd_data,
    output logic              out_valid,
    output logic              out_is_status,
    output reg_data_t         out_data
);

    rd_state_t                state;
    logic                     pend_ch1;
    logic                     pend_ch2;
    logic                     pend_trig;
    logic                     take_ch1;
    logic                     take_ch2;
    logic                     take_trig;
    logic [`SCOPE_DEPTH_LOG2:0] job_len;
    buf_ptr_t                 job_start;
    logic [`SCOPE_DEPTH_LOG2:0] rd_left;
    logic                     sel_ch2;
    // Delay line matching RAM latency
    logic                     rd_pend;
    logic                     rd_ch2;

    // Fixed service order ch1, ch2, status
    assign take_ch1  = (state == RD_IDLE) && pend_ch1;
    assign take_ch2  = (state == RD_IDLE) && !pend_ch1 && pend_ch2;
    assign take_trig = (state == RD_IDLE) && !pend_ch1 && !pend_ch2 && pend_trig;

    // Full buffer starts at oldest entry, else from 0
    assign job_len   = status.wrapped ? {1'b1, {`SCOPE_DEPTH_LOG2{1'b0}}} : {1'b0, wr_ptr};
    assign job_start = status.wrapped ? wr_ptr : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= RD_IDLE;
            pend_ch1      <= 1'b0;
            pend_ch2      <= 1'b0;
            pend_trig     <= 1'b0;
            rd_addr       <= '0;
            rd_left       <= '0;
            sel_ch2       <= 1'b0;
            rd_pend       <= 1'b0;
            rd_ch2        <= 1'b0;
            out_valid     <= 1'b0;
            out_is_status <= 1'b0;
        end else begin
            // New pulse beats a same-cycle take
            pend_ch1  <= (pend_ch1 && !take_ch1) || req.rqst_ch1;
            pend_ch2  <= (pend_ch2 && !take_ch2) || req.rqst_ch2;
            pend_trig <= (pend_trig && !take_trig) || req.rqst_trig;

            rd_pend       <= (state == RD_STREAM);
            rd_ch2        <= sel_ch2;
            out_valid     <= rd_pend || (state == RD_STATUS);
            out_is_status <= (state == RD_STATUS);

            case (state)
                RD_IDLE: begin
                    if (take_ch1 || take_ch2) begin
                        sel_ch2 <= take_ch2;
                        rd_addr <= job_start;
                        rd_left <= job_len;
                        // Empty buffer, job done at once
                        if (job_len != '0) begin
                            state <= RD_STREAM;
                        end
                    end else if (take_trig) begin
                        state <= RD_STATUS;
                    end
                end
                RD_STREAM: begin
                    // Address wraps naturally at 16
                    rd_addr <= rd_addr + 1'b1;
                    rd_left <= rd_left - 1'b1;
                    if (rd_left == 1) begin
                        state <= RD_IDLE;
                    end
                end
                RD_STATUS: state <= RD_IDLE;
                default:   state <= RD_IDLE;
            endcase
        end
    end

    // Output word, tag in the upper byte
    always_ff @(posedge clk) begin
        if (state == RD_STATUS) begin
            out_data <= reg_data_t'(status);
        end else if (rd_pend) begin
            out_data <= rd_ch2 ? {`SCOPE_TAG_CH2, rd_data.ch2}
                               : {`SCOPE_TAG_CH1, rd_data.ch1};
        end
    end

    // Idle output only drains a read or status issued the cycle before
    a_idle_valid: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && state == RD_IDLE |-> $past(rd_pend) || $past(state == RD_STATUS)
    );

endmodule

`default_nettype wire

/* design/sample_buffer.sv */
// Sample buffer
// Dual-port RAM of sample pairs, synchronous write, registered read
`timescale 1ns/1ps
`default_nettype none
`include "scope_macros.svh"

module sample_buffer import scope_pkg::*; (
    input  wire logic         clk,
    input  wire logic         wr_en,
    input  wire buf_ptr_t     wr_addr,
    input  wire sample_pair_t wr_data,
    input  wire buf_ptr_t     rd_addr,
    output sample_pair_t      rd_data
);

    sample_pair_t mem [0:(1 << `SCOPE_DEPTH_LOG2)-1];

    // Write port, driven by acquisition
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* design/acquisition_ctrl.sv */
// Acquisition control
// Run/hold FSM, circular write pointer, wrap flag and trigger crossing detect
`timescale 1ns/1ps
`default_nettype none

module acquisition_ctrl import scope_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire request_t req,
    input  wire sample_t  trig_level,
    input  wire sample_t  ch1_sample,
    input  wire sample_t  ch2_sample,
    input  wire logic     sample_valid,
    output logic          wr_en,
    output buf_ptr_t      wr_addr,
    output sample_pair_t  wr_data,
    output acq_status_t   status,
    output buf_ptr_t      wr_ptr
);

    acq_state_t state;
    sample_t    prev_ch1;
    logic       triggered;
    logic       wrapped;
    buf_ptr_t   trig_pos;
    logic       crossing;

    // Samples go straight to RAM on the strobe edge
    assign wr_en   = (state == ACQ_RUN) && sample_valid;
    assign wr_addr = wr_ptr;

    always_comb begin
        wr_data.ch1 = ch1_sample;
        wr_data.ch2 = ch2_sample;
    end

    // Rising crossing against last stored ch1, first one only
    assign crossing = !triggered && (ch1_sample >= trig_level) && (prev_ch1 < trig_level);

    always_comb begin
        status.running   = (state == ACQ_RUN);
        status.triggered = triggered;
        status.wrapped   = wrapped;
        status.rsvd      = '0;
        status.trig_pos  = trig_pos;
    end

    always_ff @(posedge clk) begin
        if (rst || req.clear) begin
            // Clear wins over everything else
            state     <= ACQ_IDLE;
            wr_ptr    <= '0;
            wrapped   <= 1'b0;
            triggered <= 1'b0;
            trig_pos  <= '0;
            prev_ch1  <= '0;
        end else begin
            if (req.stop) begin
                if (state == ACQ_RUN) begin
                    state <= ACQ_HELD;
                end
            end else if (req.start) begin
                // Resume keeps pointer and flags
                state <= ACQ_RUN;
            end

            if (wr_en) begin
                wr_ptr   <= wr_ptr + 1'b1;
                prev_ch1 <= ch1_sample;
                if (wr_ptr == '1) begin
                    wrapped <= 1'b1;
                end
                if (crossing) begin
                    triggered <= 1'b1;
                    trig_pos  <= wr_ptr;
                end
            end
        end
    end

    a_wr_in_run: assert property (
        @(posedge clk) disable iff (rst) wr_en |-> state == ACQ_RUN
    );

endmodule

`default_nettype wire

/* design/host_request_decoder.sv */
// Host request decoder
// Turns request register writes into one-cycle pulses, holds trigger level
`timescale 1ns/1ps
`default_nettype none
`include "scope_macros.svh"

module host_request_decoder import scope_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire reg_addr_t reg_addr,
    input  wire reg_data_t reg_data,
    input  wire logic      reg_wr,
    output request_t       req,
    output sample_t        trig_level
);

    logic req_wr;
    logic trig_wr;

    assign req_wr  = reg_wr && (reg_addr == `SCOPE_REQ_ADDR);
    assign trig_wr = reg_wr && (reg_addr == `SCOPE_TRIG_ADDR);

    always_ff @(posedge clk) begin
        if (rst) begin
            req        <= '0;
            trig_level <= '0;
        end else begin
            // Pulses live for one cycle only
            req <= '0;
            if (req_wr) begin
                req.start     <= reg_data[`SCOPE_START_IDX];
                // Channel readout implies stop
                // so both channels come from the same interval
                req.stop      <= reg_data[`SCOPE_STOP_IDX]
                               | reg_data[`SCOPE_RQST_CH1_IDX]
                               | reg_data[`SCOPE_RQST_CH2_IDX];
                req.rqst_ch1  <= reg_data[`SCOPE_RQST_CH1_IDX];
                req.rqst_ch2  <= reg_data[`SCOPE_RQST_CH2_IDX];
                req.rqst_trig <= reg_data[`SCOPE_RQST_TRIG_IDX];
                req.clear     <= reg_data[`SCOPE_CLEAR_IDX];
            end
            if (trig_wr) begin
                trig_level <= reg_data[`SCOPE_SAMPLE_W-1:0];
            end
        end
    end

    // Start only ever follows a request register write
    a_start_from_write: assert property (
        @(posedge clk) disable iff (rst) req.start |-> $past(req_wr)
    );

endmodule

`default_nettype wire

/* design/scope_pkg.sv */
// Scope capture types
// Vector typedefs, request and status structs, FSM encodings
`default_nettype none
`include "scope_macros.svh"

package scope_pkg;

    typedef logic [`SCOPE_ADDR_W-1:0]     reg_addr_t;
    typedef logic [`SCOPE_DATA_W-1:0]     reg_data_t;
    typedef logic [`SCOPE_SAMPLE_W-1:0]   sample_t;
    typedef logic [`SCOPE_DEPTH_LOG2-1:0] buf_ptr_t;

    // RAM word, ch1 in the low byte
    typedef struct packed {
        sample_t ch2;
        sample_t ch1;
    } sample_pair_t;

    // One-cycle command pulses from the request register
    typedef struct packed {
        logic start;
        logic stop;
        logic rqst_ch1;
        logic rqst_ch2;
        logic rqst_trig;
        logic clear;
    } request_t;

    // Also the status word on the output stream
    typedef struct packed {
        logic       running;
        logic       triggered;
        logic       wrapped;
        logic [8:0] rsvd;
        buf_ptr_t   trig_pos;
    } acq_status_t;

    typedef enum logic [1:0] {ACQ_IDLE, ACQ_RUN, ACQ_HELD} acq_state_t;
    typedef enum logic [1:0] {RD_IDLE, RD_STREAM, RD_STATUS} rd_state_t;

endpackage

`default_nettype wire

/* design/scope_macros.svh */
// Scope capture constants
// Widths, buffer depth, host register map and request bit layout
`ifndef SCOPE_MACROS_SVH
`define SCOPE_MACROS_SVH

// Host port and sample widths
`define SCOPE_ADDR_W        4
`define SCOPE_DATA_W        16
`define SCOPE_SAMPLE_W      8
// 16 sample pairs
`define SCOPE_DEPTH_LOG2    4

// Register map
`define SCOPE_REQ_ADDR      4'd0
`define SCOPE_TRIG_ADDR     4'd1

// Bit positions inside the request register
`define SCOPE_START_IDX     0
`define SCOPE_STOP_IDX      1
`define SCOPE_RQST_CH1_IDX  2
`define SCOPE_RQST_CH2_IDX  3
`define SCOPE_RQST_TRIG_IDX 4
`define SCOPE_CLEAR_IDX     5

// Upper byte tags of output words
`define SCOPE_TAG_CH1       8'h01
`define SCOPE_TAG_CH2       8'h02
`define SCOPE_TAG_STATUS    8'h10

`endif
